// File: dv/axi_mem_model.sv
/*
 * AXI read slave for the instruction cache testbench
 * Random arready delay and beat gaps, data computed from the beat address
 */

`default_nettype none

module axi_mem_model
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       arvalid,
    input  addr_t      araddr,
    input  logic [3:0] arlen,
    input  logic [2:0] arsize,
    output logic       arready,
    output logic       rvalid,
    output word_t      rdata,
    output logic       rlast,
    input  logic       rready,
    output int         ar_count,
    output addr_t      last_araddr,
    output logic [3:0] last_arlen,
    output logic [2:0] last_arsize
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t DATA_MASK = 32'h5a5a0000;

    // A handshake set up at the falling edge completes at the next rising edge
    logic  ar_fire;
    logic  r_fire;
    logic  busy;
    int    ar_delay;
    int    gap;
    int    beat;
    int    beats;
    addr_t base;

    // rst rises at time zero, so outputs are idle from the start
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            arready = 1'b0;
            rvalid = 1'b0;
            rdata = '0;
            rlast = 1'b0;
            ar_count = 0;
            last_araddr = '0;
            last_arlen = '0;
            last_arsize = '0;
            ar_fire = 1'b0;
            r_fire = 1'b0;
            busy = 1'b0;
            ar_delay = -1;
            gap = 0;
            beat = 0;
            beats = 0;
            base = '0;
        end else begin
            // Transfers of the last rising edge
            if (ar_fire) begin
                ar_count = ar_count + 1;
                busy = 1'b1;
                base = last_araddr;
                beats = int'(last_arlen) + 1;
                beat = 0;
                gap = $urandom_range(2, 0);
            end
            if (r_fire) begin
                beat = beat + 1;
                gap = $urandom_range(2, 0);
                if (beat == beats) begin
                    busy = 1'b0;
                end
            end
            ar_fire = 1'b0;
            r_fire = 1'b0;

            // 0 to 3 cycles before arready
            arready = 1'b0;
            if (arvalid && !busy) begin
                if (ar_delay < 0) begin
                    ar_delay = $urandom_range(3, 0);
                end
                if (ar_delay == 0) begin
                    arready = 1'b1;
                    ar_fire = 1'b1;
                    last_araddr = araddr;
                    last_arlen = arlen;
                    last_arsize = arsize;
                    ar_delay = -1;
                end else begin
                    ar_delay--;
                end
            end

            // Beat k carries its own address, masked
            rvalid = 1'b0;
            rlast = 1'b0;
            if (busy) begin
                if (gap == 0) begin
                    rvalid = 1'b1;
                    rdata = (base + addr_t'(beat) * 4) ^ DATA_MASK;
                    rlast = (beat == beats - 1);
                    r_fire = rready;
                end else begin
                    gap--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/icache_props.sv
/*
 * Handshake assertions for the instruction cache controller
 */

`default_nettype none

module icache_props
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         read,
    input  logic         stall,
    input  logic         arvalid,
    input  addr_t        araddr,
    input  logic         arready,
    input  logic         rready,
    input  cache_state_t state
);

    timeunit 1ns;
    timeprecision 1ps;

    // AR request must not change while it waits for arready
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");

    // R channel opens only after the AR handshake of the same miss
    r_after_ar: assert property (@(posedge clk) disable iff (rst)
        $rose(rready) |-> $past(arvalid && arready))
        else $error("rready raised without a preceding AR handshake");

    stall_needs_read: assert property (@(posedge clk) disable iff (rst)
        !stall |-> read)
        else $error("stall low while read is low");

    // During reset and on the first edge after it
    reset_idle: assert property (@(posedge clk)
        rst |=> state == IDLE && !arvalid)
        else $error("controller not idle around reset");

endmodule

bind icache_ctrl icache_props u_props (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .stall   (stall),
    .arvalid (arvalid),
    .araddr  (araddr),
    .arready (arready),
    .rready  (rready),
    .state   (state)
);

`default_nettype wire

// File: dv/icache_tb.sv
/*
 * Instruction cache testbench
 * Directed fetch tests against an AXI read model and a reference tag model
 */

`default_nettype none

`include "icache_params.svh"

module icache_tb
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SETS = 1 << `IC_INDEX_W;
    localparam word_t DATA_MASK = 32'h5a5a0000;

    // About 300 fetches of at most 40 cycles, plus margin
    localparam int MAX_FETCHES = 300;
    localparam int FETCH_CYCLES = 40;
    localparam int CYCLE_LIMIT = MAX_FETCHES * FETCH_CYCLES + 8000;

    localparam addr_t FIRST_ADDR = 32'h0000_1004;
    localparam addr_t COLD_ADDR = 32'h0004_246c;
    localparam addr_t COLD_LINE = 32'h0004_2460;
    localparam addr_t CONF_A = 32'h0010_0140;
    localparam addr_t CONF_B = 32'h0010_0940;

    logic clk = 1'b0;
    logic rst;
    logic read;
    addr_t address;
    logic stall;
    fetch_t rddata;
    logic arvalid;
    addr_t araddr;
    logic [3:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic [3:0] arid;
    logic arready;
    logic rvalid;
    word_t rdata;
    logic rlast;
    logic rready;

    int ar_count;
    addr_t last_araddr;
    logic [3:0] last_arlen;
    logic [2:0] last_arsize;

    int errors = 0;
    int checks = 0;
    int fetches = 0;
    int predicted_misses = 0;
    int cycle_count = 0;

    // Reference tag model
    logic [SETS-1:0] ref_valid;
    tag_t ref_tag [SETS];

    icache_top dut (
        .clk     (clk),
        .rst     (rst),
        .read    (read),
        .address (address),
        .stall   (stall),
        .rddata  (rddata),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arid    (arid),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rlast   (rlast),
        .rready  (rready)
    );

    axi_mem_model mem (
        .clk         (clk),
        .rst         (rst),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arsize      (arsize),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rlast       (rlast),
        .rready      (rready),
        .ar_count    (ar_count),
        .last_araddr (last_araddr),
        .last_arlen  (last_arlen),
        .last_arsize (last_arsize)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_fetch(string name, fetch_t got, fetch_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Low word from the 8-byte aligned address, high word from the next one
    function automatic fetch_t expected_fetch(addr_t a);
        addr_t base;
        base = {a[`IC_ADDR_W-1:3], 3'b000};
        return {(base + 32'd4) ^ DATA_MASK, base ^ DATA_MASK};
    endfunction

    function automatic logic predict_miss(addr_t a);
        tag_t t;
        index_t i;
        logic miss;
        t = a[`IC_ADDR_W-1 -: `IC_TAG_W];
        i = a[`IC_OFFSET_W +: `IC_INDEX_W];
        miss = !(ref_valid[i] && ref_tag[i] == t);
        ref_valid[i] = 1'b1;
        ref_tag[i] = t;
        return miss;
    endfunction

    // Called at a falling edge, returns at a falling edge with read low
    task automatic fetch_and_check(addr_t a);
        logic miss;
        int ar_before;
        int wait_cycles;
        miss = predict_miss(a);
        ar_before = ar_count;
        read = 1'b1;
        address = a;
        @(negedge clk);
        wait_cycles = 1;
        while (stall) begin
            @(negedge clk);
            wait_cycles++;
        end
        check_fetch("rddata", rddata, expected_fetch(a));
        check_count("ar transfers", ar_count - ar_before, miss ? 1 : 0);
        if (miss) begin
            // 32-byte line boundary
            check_addr("araddr", last_araddr, a & 32'hffff_ffe0);
            check_count("arlen", int'(last_arlen), 7);
            check_count("arsize", int'(last_arsize), 2);
        end else begin
            check_count("hit latency", wait_cycles, 1);
        end
        fetches++;
        predicted_misses = predicted_misses + (miss ? 1 : 0);
        // The CPU sees stall low at the next rising edge
        @(negedge clk);
        read = 1'b0;
    endtask

    task automatic report_test(string name, int err0);
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    task automatic after_reset();
        int err0;
        err0 = errors;
        check_flag("stall", stall, 1'b1);
        check_flag("arvalid", arvalid, 1'b0);
        check_flag("rready", rready, 1'b0);
        check_count("ar transfers", ar_count, 0);
        fetch_and_check(FIRST_ADDR);
        check_count("ar transfers", ar_count, 1);
        report_test("reset", err0);
    endtask

    task automatic cold_miss();
        int err0;
        int ar0;
        err0 = errors;
        ar0 = ar_count;
        fetch_and_check(COLD_ADDR);
        check_count("ar transfers", ar_count - ar0, 1);
        check_addr("araddr", last_araddr, COLD_LINE);
        check_count("arlen", int'(last_arlen), 7);
        check_count("arsize", int'(last_arsize), 2);
        check_count("arburst", int'(arburst), 1);
        check_count("arid", int'(arid), 0);
        report_test("cold miss", err0);
    endtask

    task automatic line_hits();
        int err0;
        int ar0;
        err0 = errors;
        ar0 = ar_count;
        // Odd positions also set address bit 2, which the fetch ignores
        for (int k = 0; k < 4; k++) begin
            fetch_and_check(COLD_LINE + addr_t'(8 * k + 4 * (k % 2)));
        end
        check_count("ar transfers", ar_count - ar0, 0);
        report_test("hits", err0);
    endtask

    task automatic set_conflict();
        int err0;
        int ar0;
        err0 = errors;
        ar0 = ar_count;
        for (int k = 0; k < 3; k++) begin
            fetch_and_check(CONF_A + addr_t'(8 * k));
            fetch_and_check(CONF_B);
        end
        check_count("ar transfers", ar_count - ar0, 6);
        fetch_and_check(COLD_ADDR);
        check_count("ar transfers", ar_count - ar0, 6);
        report_test("conflict", err0);
    endtask

    task automatic random_traffic();
        tag_t tag_pool [4];
        int err0;
        int ar0;
        int miss0;
        logic [1:0] pick;
        index_t idx;
        addr_t a;
        tag_pool[0] = 21'h000001;
        tag_pool[1] = 21'h000002;
        tag_pool[2] = 21'h0a5a5;
        tag_pool[3] = 21'h1fffff;
        err0 = errors;
        ar0 = ar_count;
        miss0 = predicted_misses;
        for (int n = 0; n < 250; n++) begin
            pick = 2'($urandom_range(3, 0));
            idx = index_t'($urandom_range(SETS - 1, 0));
            a = {tag_pool[pick], idx, {`IC_OFFSET_W{1'b0}}};
            a = a | addr_t'($urandom_range(31, 0));
            fetch_and_check(a);
        end
        check_count("ar transfers", ar_count - ar0, predicted_misses - miss0);
        report_test("random traffic", err0);
    endtask

    initial begin
        rst = 1'b1;
        read = 1'b0;
        address = '0;
        ref_valid = '0;
        void'($urandom(32'h45754b83));
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        after_reset();
        cold_miss();
        line_hits();
        set_conflict();
        random_traffic();

        $display("%0d checks, %0d errors, %0d fetches, %0d misses",
            checks, errors, fetches, predicted_misses);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module icache_tb -o icache_sim

./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^All checks passed$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: src/icache_ctrl.sv
/*
 * Instruction cache controller
 * Hit check against the tag array, per-set valid bits, and the miss FSM
 * that requests a line over AXI and writes it back into both arrays
 */

`default_nettype none

`include "icache_params.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // CPU fetch port
    input  logic        read,
    input  addr_t       address,
    output logic        stall,
    output fetch_t      rddata,

    // AXI read address
    output logic        arvalid,
    output addr_t       araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic [3:0]  arid,
    input  logic        arready,

    // AXI read data handshake
    input  logic        rvalid,
    output logic        rready,

    // Tag array
    output index_t      tag_addr,
    output logic        tag_write,
    output tag_t        tag_wdata,
    input  tag_t        tag_rdata,

    // Data array
    output index_t      data_addr,
    output logic        data_write,
    output line_t       data_wdata,
    input  line_t       data_rdata,

    // Fill buffer
    output logic        fill_start,
    output logic        fill_beat,
    input  line_t       fill_line,
    input  logic        fill_last
);

    localparam int SETS      = 1 << `IC_INDEX_W;
    localparam int FETCH_LSB = $clog2(`IC_FETCH_W / 8);

    cache_state_t state;
    cache_state_t state_d;

    logic [SETS-1:0] valid;

    tag_t   req_tag;
    index_t req_index;
    fsel_t  req_fsel;
    logic   hit;

    // Address fields, held stable by the CPU while stalled
    assign req_tag   = address[`IC_ADDR_W-1 -: `IC_TAG_W];
    assign req_index = address[`IC_OFFSET_W +: `IC_INDEX_W];
    assign req_fsel  = address[FETCH_LSB +: $bits(fsel_t)];

    // Both arrays follow the request index in every state
    assign tag_addr  = req_index;
    assign data_addr = req_index;

    // Array outputs are valid in LOOKUP, one clock after IDLE
    assign hit = valid[req_index] && (tag_rdata == req_tag);

    assign rddata = data_rdata[req_fsel * `IC_FETCH_W +: `IC_FETCH_W];
    assign stall  = !((state == LOOKUP) && hit);

    // Line-aligned INCR burst of 32-bit words
    assign arvalid = (state == MISS_AR);
    assign araddr  = {address[`IC_ADDR_W-1:`IC_OFFSET_W], {`IC_OFFSET_W{1'b0}}};
    assign arlen   = 4'(`IC_BEATS - 1);
    assign arsize  = 3'($clog2(`IC_WORD_W / 8));
    assign arburst = 2'b01;
    assign arid    = 4'h0;

    // R channel is never back-pressured
    assign rready    = (state == MISS_R);
    assign fill_beat = rvalid && rready;

    // Counter restart while the address phase is open
    assign fill_start = (state == MISS_AR);

    // Refill writes tag and line in the same cycle
    assign tag_write  = (state == REFILL);
    assign tag_wdata  = req_tag;
    assign data_write = (state == REFILL);
    assign data_wdata = fill_line;

    always_comb begin
        state_d = state;
        case (state)
            IDLE: begin
                if (read) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = IDLE;
                end else begin
                    state_d = MISS_AR;
                end
            end
            MISS_AR: begin
                if (arready) begin
                    state_d = MISS_R;
                end
            end
            MISS_R: begin
                // Beat count ends the burst, rlast is not needed
                if (fill_last) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // Next IDLE and LOOKUP re-read the set and hit
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_d;
        end
    end

    // One valid bit per set, only ever set by a refill
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (state == REFILL) begin
            valid[req_index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/icache_params.svh
/*
 * Instruction cache constants
 * Address, line and fetch geometry of the direct-mapped cache and its AXI refill burst
 */

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Byte address and AXI beat width
`define IC_ADDR_W   32
`define IC_WORD_W   32

// Two instructions per fetch
`define IC_FETCH_W  64

// One line is one full burst
`define IC_LINE_W   256

// 64 sets of 32 bytes
`define IC_INDEX_W  6
`define IC_OFFSET_W 5

// Whatever is left above index and offset
`define IC_TAG_W    21

// Words per line, so arlen is this minus one
`define IC_BEATS    8

`endif

// File: src/icache_pkg.sv
/*
 * Instruction cache types
 * Vector typedefs for address fields and data widths, and the controller state encoding
 */

`default_nettype none

`include "icache_params.svh"

package icache_pkg;

    typedef logic [`IC_ADDR_W-1:0]  addr_t;
    typedef logic [`IC_WORD_W-1:0]  word_t;
    typedef logic [`IC_FETCH_W-1:0] fetch_t;
    typedef logic [`IC_LINE_W-1:0]  line_t;

    // Address fields, high to low
    typedef logic [`IC_TAG_W-1:0]   tag_t;
    typedef logic [`IC_INDEX_W-1:0] index_t;

    // Fetch slot within a line, bits 4:3
    typedef logic [$clog2(`IC_LINE_W / `IC_FETCH_W)-1:0] fsel_t;

    // Beat position within a refill burst
    typedef logic [$clog2(`IC_BEATS)-1:0] beat_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_AR,
        MISS_R,
        REFILL
    } cache_state_t;

endpackage

`default_nettype wire

// File: src/icache_top.sv
/*
 * Direct-mapped instruction cache
 * Controller, tag and data arrays and the refill collector between CPU fetch and AXI read
 */

`default_nettype none

`include "icache_params.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        read,
    input  addr_t       address,
    output logic        stall,
    output fetch_t      rddata,

    output logic        arvalid,
    output addr_t       araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic [3:0]  arid,
    input  logic        arready,

    // rlast is redundant with the controller's own beat count
    input  logic        rvalid,
    input  word_t       rdata,
    input  logic        rlast,
    output logic        rready
);

    localparam int SETS = 1 << `IC_INDEX_W;

    index_t tag_addr;
    logic   tag_write;
    tag_t   tag_wdata;
    tag_t   tag_rdata;

    index_t data_addr;
    logic   data_write;
    line_t  data_wdata;
    line_t  data_rdata;

    logic   fill_start;
    logic   fill_beat;
    line_t  fill_line;
    logic   fill_last;

    icache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .read       (read),
        .address    (address),
        .stall      (stall),
        .rddata     (rddata),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .arid       (arid),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .tag_addr   (tag_addr),
        .tag_write  (tag_write),
        .tag_wdata  (tag_wdata),
        .tag_rdata  (tag_rdata),
        .data_addr  (data_addr),
        .data_write (data_write),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .fill_start (fill_start),
        .fill_beat  (fill_beat),
        .fill_line  (fill_line),
        .fill_last  (fill_last)
    );

    line_ram #(
        .WIDTH (`IC_TAG_W),
        .DEPTH (SETS)
    ) tag_ram (
        .clk   (clk),
        .write (tag_write),
        .addr  (tag_addr),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    line_ram #(
        .WIDTH (`IC_LINE_W),
        .DEPTH (SETS)
    ) data_ram (
        .clk   (clk),
        .write (data_write),
        .addr  (data_addr),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    line_fill_buffer u_fill (
        .clk        (clk),
        .rst        (rst),
        .start      (fill_start),
        .beat_valid (fill_beat),
        .beat_data  (rdata),
        .line       (fill_line),
        .last_beat  (fill_last)
    );

endmodule

`default_nettype wire

// File: src/line_fill_buffer.sv
/*
 * Refill line collector
 * Packs the AXI read beats of one burst into a full line, word 0 lowest
 */

`default_nettype none

`include "icache_params.svh"

module line_fill_buffer
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  beat_valid,
    input  word_t beat_data,
    output line_t line,
    output logic  last_beat
);

    beat_t cnt;

    // Beat counter, cleared while the request is outstanding
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= '0;
        end else if (beat_valid) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            line[cnt * `IC_WORD_W +: `IC_WORD_W] <= beat_data;
        end
    end

    // High together with the eighth accepted word
    assign last_beat = beat_valid && (cnt == beat_t'(`IC_BEATS - 1));

endmodule

`default_nettype wire

// File: src/line_ram.sv
/*
 * Single-port line array
 * Synchronous write and registered read, one entry per cache set
 */

`default_nettype none

`include "icache_params.svh"

module line_ram
    import icache_pkg::*;
#(
    parameter int WIDTH = `IC_LINE_W,
    parameter int DEPTH = 1 << `IC_INDEX_W
) (
    input  logic             clk,
    input  logic             write,
    input  index_t           addr,
    input  logic [WIDTH-1:0] wdata,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= wdata;
        end
    end

    // Read data lags the address by one clock
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/icache_pkg.sv
src/line_ram.sv
src/line_fill_buffer.sv
src/icache_ctrl.sv
src/icache_top.sv
dv/axi_mem_model.sv
dv/icache_props.sv
dv/icache_tb.sv
